/* rtl/axi_ram_pkg.sv */
/*
 memory geometry for the AXI burst RAM
 byte address, word and strobe types, RAM index width and the queue depth
 shared by every block of the slave
 */
package axi_ram_pkg;

    localparam int ADDR_WIDTH      = 12;                        // byte address
    localparam int DATA_WIDTH      = 32;
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;            // one bit per byte lane
    localparam int ADDR_LSB        = $clog2(STRB_WIDTH);        // byte offset inside a word
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - ADDR_LSB;     // RAM index

    // depth of the aw, b and r queues
    localparam int FIFO_DEPTH      = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

endpackage

/* rtl/axi_burst_pkg.sv */
/*
 AXI4 protocol definitions for the burst RAM slave
 burst type encoding and the packed payload of each channel
 AW and AR share one request struct
 */
package axi_burst_pkg;

    localparam int ID_WIDTH  = 4;
    localparam int LEN_WIDTH = 8;       // AxLEN, beats minus one
    localparam int MAX_BURST = 16;      // longest burst the engines track

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // reserved code is handled like INCR
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

    typedef struct packed {
        logic [ID_WIDTH-1:0]  id;
        axi_ram_pkg::addr_t   addr;
        logic [LEN_WIDTH-1:0] len;
        burst_e               burst;
    } axi_ax_t;

    typedef struct packed {
        axi_ram_pkg::data_t data;
        axi_ram_pkg::strb_t strb;
        logic               last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        axi_ram_pkg::data_t  data;
        logic [1:0]          resp;
        logic                last;
    } axi_r_t;

endpackage

/* rtl/sync_fifo.sv */
/*
 small synchronous FIFO with a valid/ready interface on both sides
 the payload type is a parameter, so one block serves every queue
 a pushed entry shows up on pop_data one cycle later
 */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  logic                       push_valid,
    input  payload_t                   push_data,
    output logic                       push_ready,
    output logic                       pop_valid,
    output payload_t                   pop_data,
    input  logic                       pop_ready,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t             mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 push_fire;
    logic                 pop_fire;

    assign push_ready = (count < DEPTH);    // refuse when full
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge S_AXI_ACLK) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* rtl/burst_addr_gen.sv */
/*
 next-beat byte address for FIXED, INCR and WRAP bursts
 purely combinational, every beat is one full word
 WRAP stays inside the aligned block of len+1 words
 */
`timescale 1ns/1ps

module burst_addr_gen (
    input  axi_ram_pkg::addr_t                  addr,
    input  logic [axi_burst_pkg::LEN_WIDTH-1:0] len,
    input  axi_burst_pkg::burst_e               burst,
    output axi_ram_pkg::addr_t                  next_addr
);

    import axi_ram_pkg::*;
    import axi_burst_pkg::*;

    logic [WORD_ADDR_WIDTH-1:0] word;
    logic [WORD_ADDR_WIDTH-1:0] word_inc;
    logic [WORD_ADDR_WIDTH-1:0] wrap_mask;
    logic [WORD_ADDR_WIDTH-1:0] wrap_word;

    assign word      = addr[ADDR_WIDTH-1:ADDR_LSB];
    assign word_inc  = word + 1'b1;

    // len+1 is a power of two for WRAP, so len masks the offset in the block
    assign wrap_mask = WORD_ADDR_WIDTH'(len);
    assign wrap_word = (word & ~wrap_mask) | (word_inc & wrap_mask);

    always_comb begin
        case (burst)
            BURST_FIXED: next_addr = addr;
            BURST_WRAP:  next_addr = {wrap_word, {ADDR_LSB{1'b0}}};
            default:     next_addr = {word_inc, {ADDR_LSB{1'b0}}};  // INCR and RSVD
        endcase
    end

endmodule

/* rtl/ram_pdp.sv */
/*
 pseudo dual-port RAM, one write port and one read port
 byte-lane write enables, read data registered one cycle after re
 contents come up undefined
 */
`timescale 1ns/1ps

module ram_pdp (
    input  logic                                S_AXI_ACLK,
    input  logic                                we,
    input  logic [axi_ram_pkg::WORD_ADDR_WIDTH-1:0] waddr,
    input  axi_ram_pkg::data_t                  wdata,
    input  axi_ram_pkg::strb_t                  wstrb,
    input  logic                                re,
    input  logic [axi_ram_pkg::WORD_ADDR_WIDTH-1:0] raddr,
    output axi_ram_pkg::data_t                  rdata
);

    import axi_ram_pkg::*;

    localparam int WORDS = 2 ** WORD_ADDR_WIDTH;

    data_t mem [WORDS];

    always_ff @(posedge S_AXI_ACLK) begin
        if (we) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (wstrb[i]) begin
                    mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];    // only strobed lanes
                end
            end
        end
        if (re) begin
            rdata <= mem[raddr];    // holds while re is low
        end
    end

endmodule

/* rtl/write_engine.sv */
/*
 write side of the burst RAM
 takes one queued AW request at a time, writes each accepted W beat
 into the RAM at the current burst address and pushes a B response
 on the last beat; the next request is taken on that same edge
 */
`timescale 1ns/1ps

module write_engine (
    input  logic                                    S_AXI_ACLK,
    input  logic                                    S_AXI_ARESETN,
    input  logic                                    req_valid,
    input  axi_burst_pkg::axi_ax_t                  req,
    output logic                                    req_ready,
    input  logic                                    w_valid,
    input  axi_burst_pkg::axi_w_t                   w,
    output logic                                    w_ready,
    output logic                                    b_push_valid,
    input  logic                                    b_push_ready,
    output axi_burst_pkg::axi_b_t                   b_push,
    output logic                                    ram_we,
    output logic [axi_ram_pkg::WORD_ADDR_WIDTH-1:0] ram_waddr,
    output axi_ram_pkg::data_t                      ram_wdata,
    output axi_ram_pkg::strb_t                      ram_wstrb
);

    import axi_ram_pkg::*;
    import axi_burst_pkg::*;

    logic    active;
    axi_ax_t cur;           // active burst, addr steps every beat
    addr_t   next_addr;
    logic    w_fire;
    logic    last_fire;
    logic    req_fire;

    // stall W while the b queue has no room for a response
    assign w_ready   = active && b_push_ready;
    assign w_fire    = w_valid && w_ready;
    assign last_fire = w_fire && w.last;
    assign req_ready = !active || last_fire;
    assign req_fire  = req_valid && req_ready;

    assign ram_we    = w_fire;
    assign ram_waddr = cur.addr[ADDR_WIDTH-1:ADDR_LSB];
    assign ram_wdata = w.data;
    assign ram_wstrb = w.strb;

    assign b_push_valid = last_fire;
    assign b_push       = '{id: cur.id, resp: RESP_OKAY};

    burst_addr_gen i_addr_gen (
        .addr      (cur.addr),
        .len       (cur.len),
        .burst     (cur.burst),
        .next_addr (next_addr)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            active <= 1'b0;
        end else if (req_fire) begin
            active <= 1'b1;     // also covers back-to-back hand-over
        end else if (last_fire) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (req_fire) begin
            cur <= req;
        end else if (w_fire) begin
            cur.addr <= next_addr;
        end
    end

endmodule

/* rtl/read_engine.sv */
/*
 read side of the burst RAM
 runs one AR burst at a time and issues one RAM read per cycle while
 queued beats plus the read in flight stay below the r queue depth
 a one-cycle tag stage pairs each RAM word with its ID and last flag
 */
`timescale 1ns/1ps

module read_engine (
    input  logic                                            S_AXI_ACLK,
    input  logic                                            S_AXI_ARESETN,
    input  logic                                            ar_valid,
    input  axi_burst_pkg::axi_ax_t                          ar,
    output logic                                            ar_ready,
    output logic                                            ram_re,
    output logic [axi_ram_pkg::WORD_ADDR_WIDTH-1:0]         ram_raddr,
    input  axi_ram_pkg::data_t                              ram_rdata,
    input  logic [$clog2(axi_ram_pkg::FIFO_DEPTH+1)-1:0]    r_count,
    output logic                                            r_push_valid,
    input  logic                                            r_push_ready,
    output axi_burst_pkg::axi_r_t                           r_push
);

    import axi_ram_pkg::*;
    import axi_burst_pkg::*;

    localparam int CNT_WIDTH  = $clog2(FIFO_DEPTH + 1);
    localparam int BEAT_WIDTH = $clog2(MAX_BURST);

    logic                  active;
    axi_ax_t               cur;
    addr_t                 next_addr;
    logic [BEAT_WIDTH-1:0] beat_cnt;    // beats issued so far
    logic                  last_beat;
    logic [CNT_WIDTH:0]    used;        // queued plus in flight
    logic                  stall;
    logic                  ar_fire;
    logic                  tag_valid;
    logic                  tag_last;
    logic [ID_WIDTH-1:0]   tag_id;

    assign ar_ready  = !active;
    assign ar_fire   = ar_valid && ar_ready;
    assign last_beat = (beat_cnt == cur.len[BEAT_WIDTH-1:0]);

    assign used  = r_count + tag_valid;
    // hold the tag stage if the queue refuses, RAM output stays put with re low
    assign stall = r_push_valid && !r_push_ready;

    assign ram_re    = active && (used < FIFO_DEPTH) && !stall;
    assign ram_raddr = cur.addr[ADDR_WIDTH-1:ADDR_LSB];

    assign r_push_valid = tag_valid;
    assign r_push       = '{id: tag_id, data: ram_rdata, resp: RESP_OKAY, last: tag_last};

    burst_addr_gen i_addr_gen (
        .addr      (cur.addr),
        .len       (cur.len),
        .burst     (cur.burst),
        .next_addr (next_addr)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            active    <= 1'b0;
            beat_cnt  <= '0;
            tag_valid <= 1'b0;
        end else begin
            if (ar_fire) begin
                active   <= 1'b1;
                beat_cnt <= '0;
            end else if (ram_re) begin
                if (last_beat) begin
                    active <= 1'b0;     // arready back next cycle
                end
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (!stall) begin
                tag_valid <= ram_re;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_fire) begin
            cur <= ar;
        end else if (ram_re) begin
            cur.addr <= next_addr;
        end
        if (ram_re) begin
            tag_id   <= cur.id;
            tag_last <= last_beat;
        end
    end

endmodule

/* rtl/axi_burst_ram.sv */
/*
 AXI4 burst memory slave, top level
 aw queue feeds the write engine, B responses and R beats leave
 through their own queues, both engines share one pseudo dual-port RAM
 each channel is a valid, a ready and one packed payload struct
 */
`timescale 1ns/1ps

module axi_burst_ram (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi_burst_pkg::axi_ax_t aw,
    input  logic                   w_valid,
    output logic                   w_ready,
    input  axi_burst_pkg::axi_w_t  w,
    output logic                   b_valid,
    input  logic                   b_ready,
    output axi_burst_pkg::axi_b_t  b,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  axi_burst_pkg::axi_ax_t ar,
    output logic                   r_valid,
    input  logic                   r_ready,
    output axi_burst_pkg::axi_r_t  r
);

    import axi_ram_pkg::*;
    import axi_burst_pkg::*;

    // aw queue to write engine
    logic    wq_valid;
    logic    wq_ready;
    axi_ax_t wq_req;

    // write engine to b queue
    logic   bq_valid;
    logic   bq_ready;
    axi_b_t bq_data;

    // read engine to r queue
    logic                           rq_valid;
    logic                           rq_ready;
    axi_r_t                         rq_data;
    logic [$clog2(FIFO_DEPTH+1)-1:0] rq_count;

    // RAM ports
    logic                       ram_we;
    logic [WORD_ADDR_WIDTH-1:0] ram_waddr;
    data_t                      ram_wdata;
    strb_t                      ram_wstrb;
    logic                       ram_re;
    logic [WORD_ADDR_WIDTH-1:0] ram_raddr;
    data_t                      ram_rdata;

    sync_fifo #(
        .payload_t (axi_ax_t),
        .DEPTH     (FIFO_DEPTH)
    ) i_aw_fifo (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push_valid    (aw_valid),
        .push_data     (aw),
        .push_ready    (aw_ready),
        .pop_valid     (wq_valid),
        .pop_data      (wq_req),
        .pop_ready     (wq_ready),
        .count         ()
    );

    write_engine i_write_engine (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req_valid     (wq_valid),
        .req           (wq_req),
        .req_ready     (wq_ready),
        .w_valid       (w_valid),
        .w             (w),
        .w_ready       (w_ready),
        .b_push_valid  (bq_valid),
        .b_push_ready  (bq_ready),
        .b_push        (bq_data),
        .ram_we        (ram_we),
        .ram_waddr     (ram_waddr),
        .ram_wdata     (ram_wdata),
        .ram_wstrb     (ram_wstrb)
    );

    // absorbs B back-pressure
    sync_fifo #(
        .payload_t (axi_b_t),
        .DEPTH     (FIFO_DEPTH)
    ) i_b_fifo (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push_valid    (bq_valid),
        .push_data     (bq_data),
        .push_ready    (bq_ready),
        .pop_valid     (b_valid),
        .pop_data      (b),
        .pop_ready     (b_ready),
        .count         ()
    );

    read_engine i_read_engine (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .ar_ready      (ar_ready),
        .ram_re        (ram_re),
        .ram_raddr     (ram_raddr),
        .ram_rdata     (ram_rdata),
        .r_count       (rq_count),
        .r_push_valid  (rq_valid),
        .r_push_ready  (rq_ready),
        .r_push        (rq_data)
    );

    // occupancy goes back to the read engine as credit
    sync_fifo #(
        .payload_t (axi_r_t),
        .DEPTH     (FIFO_DEPTH)
    ) i_r_fifo (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push_valid    (rq_valid),
        .push_data     (rq_data),
        .push_ready    (rq_ready),
        .pop_valid     (r_valid),
        .pop_data      (r),
        .pop_ready     (r_ready),
        .count         (rq_count)
    );

    ram_pdp i_ram (
        .S_AXI_ACLK (S_AXI_ACLK),
        .we         (ram_we),
        .waddr      (ram_waddr),
        .wdata      (ram_wdata),
        .wstrb      (ram_wstrb),
        .re         (ram_re),
        .raddr      (ram_raddr),
        .rdata      (ram_rdata)
    );

endmodule

/* verification/axi_burst_ram_assertions.sv */
/*
 handshake checks bound into the AXI burst RAM top level
 B and R payloads hold while stalled, W is refused while the b queue is full
 b queue occupancy is rebuilt from the W last beats and the B handshakes
 fail_count is read by the testbench at the end of the run
 */
`timescale 1ns/1ps

module axi_burst_ram_assertions (
    input logic                  S_AXI_ACLK,
    input logic                  S_AXI_ARESETN,
    input logic                  w_valid,
    input logic                  w_ready,
    input axi_burst_pkg::axi_w_t w,
    input logic                  b_valid,
    input logic                  b_ready,
    input axi_burst_pkg::axi_b_t b,
    input logic                  r_valid,
    input logic                  r_ready,
    input axi_burst_pkg::axi_r_t r
);

    import axi_ram_pkg::*;

    int                               fail_count = 0;
    logic [$clog2(FIFO_DEPTH+1)-1:0] b_pending;     // responses owed but not yet taken

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            b_pending <= '0;
        end else begin
            case ({w_valid && w_ready && w.last, b_valid && b_ready})
                2'b10:   b_pending <= b_pending + 1'b1;
                2'b01:   b_pending <= b_pending - 1'b1;
                default: b_pending <= b_pending;
            endcase
        end
    end

    b_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (b_valid && !b_ready) |=> (b_valid && $stable(b)))
        else begin
            $error("B payload changed or dropped while stalled");
            fail_count++;
        end

    r_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else begin
            $error("R payload changed or dropped while stalled");
            fail_count++;
        end

    // no beat may complete a burst with nowhere to put its response
    w_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (b_valid && !b_ready && (b_pending == FIFO_DEPTH)) |-> !w_ready)
        else begin
            $error("wready high while the b queue is full");
            fail_count++;
        end

endmodule

bind axi_burst_ram axi_burst_ram_assertions i_assertions (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .w             (w),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .b             (b),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .r             (r)
);

/* verification/tb_axi_burst_ram.sv */
/*
 trace-driven testbench for the AXI burst RAM
 writes stream AW and W from queues, B is checked in order against the
 issued IDs, each read waits for the outstanding writes and checks its beats
 bready and rready are toggled from an LFSR
 */
`timescale 1ns/1ps

module tb_axi_burst_ram;

    import axi_ram_pkg::*;
    import axi_burst_pkg::*;

    localparam int DRV_TIMEOUT  = 500;      // cycles per handshake or beat
    localparam int WAIT_TIMEOUT = 4000;
    localparam int TRACE_WORDS  = 512;

    logic    S_AXI_ACLK;
    logic    S_AXI_ARESETN;
    logic    aw_valid;
    logic    aw_ready;
    axi_ax_t aw;
    logic    w_valid;
    logic    w_ready;
    axi_w_t  w;
    logic    b_valid;
    logic    b_ready;
    axi_b_t  b;
    logic    ar_valid;
    logic    ar_ready;
    axi_ax_t ar;
    logic    r_valid;
    logic    r_ready;
    axi_r_t  r;

    logic [31:0]         trace_mem [TRACE_WORDS];
    axi_ax_t             aw_q [$];
    axi_w_t              w_q [$];
    logic [ID_WIDTH-1:0] bid_q [$];     // IDs still waiting for B
    logic [15:0]         lfsr = 16'd8763;
    logic                stop_run;
    int                  errors;
    int                  b_count;
    int                  r_beats;

    axi_burst_ram i_axi_burst_ram (.*);

    always #5 S_AXI_ACLK = ~S_AXI_ACLK;

    // galois, taps 16 14 13 11
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("ERR %s expected %h got %h at %0t", name, expected, actual, $time);
    endtask

    // returns on a clock edge once every queued write has its B
    task automatic wait_writes_done();
        int n;
        n = 0;
        while (aw_q.size() != 0 || w_q.size() != 0 || bid_q.size() != 0) begin
            n++;
            if (n > WAIT_TIMEOUT) begin
                errors++;
                $display("writes did not complete, %0d B responses missing", bid_q.size());
                stop_run = 1'b1;
                return;
            end
            @(posedge S_AXI_ACLK);
        end
    endtask

    task automatic run_read(input axi_ax_t req, input int base);
        int n;
        int beat;
        #1;
        ar       = req;
        ar_valid = 1'b1;
        n        = 0;
        @(posedge S_AXI_ACLK);
        while (!ar_ready) begin
            n++;
            if (n > DRV_TIMEOUT) begin
                errors++;
                $display("read with id %h was never accepted on AR", req.id);
                stop_run = 1'b1;
                return;
            end
            @(posedge S_AXI_ACLK);
        end
        #1;
        ar_valid = 1'b0;
        beat     = 0;
        n        = 0;
        while (beat <= int'(req.len)) begin
            @(posedge S_AXI_ACLK);
            if (r_valid && r_ready) begin
                if (r.data !== trace_mem[base + beat]) begin
                    report_mismatch("r.data", trace_mem[base + beat], r.data);
                end
                if (r.id !== req.id) begin
                    report_mismatch("r.id", req.id, r.id);
                end
                if (r.resp !== RESP_OKAY) begin
                    report_mismatch("r.resp", RESP_OKAY, r.resp);
                end
                if (r.last !== (beat == int'(req.len))) begin
                    report_mismatch("r.last", beat == int'(req.len), r.last);
                end
                beat++;
                r_beats++;
                n = 0;
            end else begin
                n++;
                if (n > DRV_TIMEOUT) begin
                    errors++;
                    $display("read id %h stalled after %0d of %0d beats",
                             req.id, beat, req.len + 1);
                    stop_run = 1'b1;
                    return;
                end
            end
        end
    endtask

    initial begin
        int n;
        aw_valid = 1'b0;
        aw       = '0;
        forever begin
            #1;
            if (aw_q.size() == 0) begin
                aw_valid = 1'b0;
                @(posedge S_AXI_ACLK);
            end else begin
                aw       = aw_q[0];     // next request back to back
                aw_valid = 1'b1;
                n        = 0;
                @(posedge S_AXI_ACLK);
                while (!aw_ready && n < DRV_TIMEOUT) begin
                    n++;
                    @(posedge S_AXI_ACLK);
                end
                if (!aw_ready) begin
                    errors++;
                    $display("AW with id %h was not accepted in time", aw.id);
                end
                aw_q.delete(0);
            end
        end
    end

    initial begin
        int n;
        w_valid = 1'b0;
        w       = '0;
        forever begin
            #1;
            if (w_q.size() == 0) begin
                w_valid = 1'b0;
                @(posedge S_AXI_ACLK);
            end else begin
                w       = w_q[0];
                w_valid = 1'b1;
                n       = 0;
                @(posedge S_AXI_ACLK);
                while (!w_ready && n < DRV_TIMEOUT) begin
                    n++;
                    @(posedge S_AXI_ACLK);
                end
                if (!w_ready) begin
                    errors++;
                    $display("W beat %h was not accepted in time", w.data);
                end
                w_q.delete(0);
            end
        end
    end

    // random back-pressure on B and R
    initial begin
        b_ready = 1'b0;
        r_ready = 1'b0;
        forever begin
            @(posedge S_AXI_ACLK);
            #1;
            b_ready = next_bit();
            r_ready = next_bit();
        end
    end

    // B must come back in request order
    always @(posedge S_AXI_ACLK) begin
        if (b_valid && b_ready) begin
            if (bid_q.size() == 0) begin
                errors++;
                $display("B response arrived with no write outstanding");
            end else begin
                if (b.id !== bid_q[0]) begin
                    report_mismatch("b.id", bid_q[0], b.id);
                end
                if (b.resp !== RESP_OKAY) begin
                    report_mismatch("b.resp", RESP_OKAY, b.resp);
                end
                bid_q.delete(0);
                b_count++;
            end
        end
    end

    initial begin
        int      idx;
        int      beat;
        axi_ax_t req;
        axi_w_t  wbeat;
        S_AXI_ACLK    = 1'b0;
        S_AXI_ARESETN = 1'b0;
        ar_valid      = 1'b0;
        ar            = '0;
        stop_run      = 1'b0;
        errors        = 0;
        b_count       = 0;
        r_beats       = 0;
        $readmemh("verification/axi_burst_ram_trace.txt", trace_mem);
        repeat (3) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        idx = 0;
        while (!stop_run && trace_mem[idx] !== 32'h0) begin
            req.id    = trace_mem[idx + 1][ID_WIDTH-1:0];
            req.addr  = trace_mem[idx + 2][ADDR_WIDTH-1:0];
            req.len   = trace_mem[idx + 3][LEN_WIDTH-1:0];
            req.burst = burst_e'(trace_mem[idx + 4][1:0]);
            if (trace_mem[idx] === 32'h1) begin
                idx += 5;
                for (beat = 0; beat <= int'(req.len); beat++) begin
                    wbeat.data = trace_mem[idx];
                    wbeat.strb = trace_mem[idx + 1][STRB_WIDTH-1:0];
                    wbeat.last = (beat == int'(req.len));
                    w_q.push_back(wbeat);
                    idx += 2;
                end
                bid_q.push_back(req.id);
                aw_q.push_back(req);
            end else if (trace_mem[idx] === 32'h2) begin
                wait_writes_done();     // read after write
                if (!stop_run) begin
                    run_read(req, idx + 5);
                end
                idx += 5 + int'(req.len) + 1;
            end else begin
                errors++;
                $display("unknown record kind %h at trace word %0d", trace_mem[idx], idx);
                stop_run = 1'b1;
            end
        end
        if (!stop_run) begin
            wait_writes_done();
        end

        @(posedge S_AXI_ACLK);
        if (b_valid || r_valid) begin
            errors++;
            $display("a response was left over after the last transaction");
        end
        if (b_count == 0 || r_beats == 0) begin
            errors++;
            $display("the trace produced no write or no read traffic");
        end
        errors += i_axi_burst_ram.i_assertions.fail_count;
        $display("b responses %0d, r beats %0d, errors %0d", b_count, r_beats, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verification/axi_burst_ram_trace.txt */
// record: kind id addr len burst; kind 1 = write, 2 = read, 0 = end of trace
// a write then has len+1 pairs of data and strb, a read len+1 expected data words
// INCR write with full strobes, read back
1 1 100 3 1
03020100 f 07060504 f 0b0a0908 f 0f0e0d0c f
2 2 100 3 1
03020100 07060504 0b0a0908 0f0e0d0c
// partial strobes over known words
1 3 104 1 1
aaaaaaaa 5 bbbbbbbb c
2 4 100 3 1
03020100 07aa05aa bbbb0908 0f0e0d0c
// reserved burst code reads like INCR
2 0 108 1 3
bbbb0908 0f0e0d0c
// WRAP of 4 from mid-block, read back from another offset
1 5 208 3 2
a0000000 f a1111111 f a2222222 f a3333333 f
2 6 204 3 2
a3333333 a0000000 a1111111 a2222222
// FIXED keeps only the last beat
1 7 300 2 0
c0c0c0c0 f c1c1c1c1 f c2c2c2c2 f
2 8 300 2 0
c2c2c2c2 c2c2c2c2 c2c2c2c2
// back-to-back writes filling 400 to 43c
1 9 400 1 1
40000000 f 40000001 f
1 a 408 1 1
40000002 f 40000003 f
1 b 410 3 1
40000004 f 40000005 f 40000006 f 40000007 f
1 c 420 3 1
40000008 f 40000009 f 4000000a f 4000000b f
1 d 430 3 1
4000000c f 4000000d f 4000000e f 4000000f f
// 16-beat read under random rready
2 f 400 f 1
40000000 40000001 40000002 40000003 40000004 40000005 40000006 40000007
40000008 40000009 4000000a 4000000b 4000000c 4000000d 4000000e 4000000f
0

/* axi_burst_ram.f */
rtl/axi_ram_pkg.sv
rtl/axi_burst_pkg.sv
rtl/sync_fifo.sv
rtl/burst_addr_gen.sv
rtl/ram_pdp.sv
rtl/write_engine.sv
rtl/read_engine.sv
rtl/axi_burst_ram.sv
verification/axi_burst_ram_assertions.sv
verification/tb_axi_burst_ram.sv

/* Bender.yml */
package:
  name: axi_burst_ram

sources:
  # packages first, then leaf blocks, then the top level
  - rtl/axi_ram_pkg.sv
  - rtl/axi_burst_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/burst_addr_gen.sv
  - rtl/ram_pdp.sv
  - rtl/write_engine.sv
  - rtl/read_engine.sv
  - rtl/axi_burst_ram.sv
  - target: test
    files:
      - verification/axi_burst_ram_assertions.sv
      - verification/tb_axi_burst_ram.sv
